/* rtl/vlsu_pkg.sv */
// Shared LSU types for two lanes of 32-bit banks; bases must be element aligned, vl*width <= 64 B
package vlsu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Lanes, memory ports and register file banks come in equal numbers
  localparam int unsigned NR_PORTS   = 2;
  localparam int unsigned WORD_BYTES = 4;
  // Bank words per vector register in each bank
  localparam int unsigned VREG_WORDS = 8;
  localparam int unsigned NR_VREGS   = 32;
  // Loads a single lane may have outstanding at the memory
  localparam int unsigned LOAD_DEPTH = 4;
  localparam int unsigned MEM_AW     = 32;

  typedef logic [8*WORD_BYTES-1:0] word_t;
  typedef logic [WORD_BYTES-1:0]   strb_t;
  // Element count, 0 up to 64
  typedef logic [6:0]              vl_t;
  // Register number times VREG_WORDS plus the word index
  typedef logic [7:0]              vrf_addr_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [1:0] {
    OP_VLE  = 2'd0,
    OP_VLSE = 2'd1,
    OP_VSE  = 2'd2,
    OP_VSSE = 2'd3
  } vlsu_op_e;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  ////////////////////
  // Transfers
  ////////////////////

  typedef struct packed {
    vlsu_op_e                      op;
    vsew_e                         vsew;
    vl_t                           vl;
    logic [MEM_AW-1:0]             base;
    // Byte distance between elements of a strided access
    logic [MEM_AW-1:0]             stride;
    logic [$clog2(NR_VREGS)-1:0]   vreg;
    logic [3:0]                    id;
  } vlsu_req_t;

  typedef struct packed {
    logic [3:0]                    id;
    logic [$clog2(NR_VREGS)-1:0]   vreg;
  } vlsu_rsp_t;

  typedef struct packed {
    logic [MEM_AW-1:0] addr;
    logic              we;
    strb_t             strb;
    word_t             wdata;
  } mem_req_t;

  typedef struct packed {
    vrf_addr_t addr;
    word_t     data;
    strb_t     be;
  } vrf_wr_t;

endpackage

/* rtl/vlsu_dispatch.sv */
// Holds one instruction at a time; req_valid_i may only pulse while req_ready_o is high
`timescale 1ns/1ps

module vlsu_dispatch (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  vlsu_pkg::vlsu_req_t req_i,
  input  logic                finish_i,
  output logic                req_ready_o,
  output logic                start_o,
  output vlsu_pkg::vlsu_req_t active_o
);

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e state_q;
  logic   accept;

  // Ready only while no instruction is in flight
  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      start_o  <= 1'b0;
      active_o <= '0;
    end else begin
      // Lanes and completion see the held instruction together with start
      start_o <= accept;
      if (accept) begin
        state_q  <= BUSY;
        active_o <= req_i;
      end else if (finish_i) begin
        state_q <= IDLE;
      end
    end
  end

endmodule

/* rtl/vlsu_lane.sv */
// One bank and port lane; element-aligned base, memory takes every request, results come in order
`timescale 1ns/1ps

module vlsu_lane (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  int unsigned         lane_idx_i,
  input  logic                start_i,
  input  vlsu_pkg::vlsu_req_t req_i,
  output logic                vrf_re_o,
  output vlsu_pkg::vrf_addr_t vrf_raddr_o,
  input  vlsu_pkg::word_t     vrf_rdata_i,
  output logic                vrf_we_o,
  output vlsu_pkg::vrf_wr_t   vrf_wr_o,
  output logic                mem_req_valid_o,
  output vlsu_pkg::mem_req_t  mem_req_o,
  input  logic                mem_res_valid_i,
  input  vlsu_pkg::word_t     mem_rdata_i,
  output logic                done_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } state_e;

  // Register byte offset, wide enough for the skip past the last element
  typedef logic [7:0] rbyte_t;
  typedef logic [vlsu_pkg::MEM_AW-1:0] addr_t;
  typedef logic [$clog2(vlsu_pkg::LOAD_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(vlsu_pkg::LOAD_DEPTH):0] cnt_t;

  typedef struct packed {
    vlsu_pkg::vrf_addr_t vaddr;
    logic [1:0]          boff;
    logic [1:0]          moff;
    vlsu_pkg::vsew_e     vsew;
  } ld_entry_t;

  typedef struct packed {
    addr_t           maddr;
    logic [1:0]      boff;
    logic [1:0]      moff;
    vlsu_pkg::vsew_e vsew;
  } st_stage_t;

  function automatic vlsu_pkg::strb_t elem_mask(vlsu_pkg::vsew_e vsew);
    case (vsew)
      vlsu_pkg::EW_8:  return 4'b0001;
      vlsu_pkg::EW_16: return 4'b0011;
      default:         return 4'b1111;
    endcase
  endfunction

  // Moves byte k to byte (k + n) mod 4
  function automatic vlsu_pkg::word_t rotl_bytes(vlsu_pkg::word_t w, logic [1:0] n);
    case (n)
      2'd1:    return {w[23:0], w[31:24]};
      2'd2:    return {w[15:0], w[31:16]};
      2'd3:    return {w[7:0], w[31:8]};
      default: return w;
    endcase
  endfunction

  state_e              state_q;
  rbyte_t              byte_q, cur_byte, nxt_byte;
  logic                done_q, is_store, is_strided, walking;
  logic                elem_valid, last_elem, ld_credit, issue;
  logic [8:0]          vl_bytes;
  logic [2:0]          esize;
  vlsu_pkg::vl_t       elem_idx;
  addr_t               step, elem_addr;
  vlsu_pkg::vrf_addr_t cur_vaddr;
  ld_entry_t           ldq_q [vlsu_pkg::LOAD_DEPTH];
  ld_entry_t           head;
  ptr_t                wptr_q, rptr_q;
  cnt_t                ld_cnt_q;
  logic                ld_push, ld_pop, wr_valid_q, st_valid_q;
  vlsu_pkg::vrf_wr_t   wr_q;
  st_stage_t           st_q;

  //////////////////////
  // Element walker
  //////////////////////

  assign is_store   = (req_i.op == vlsu_pkg::OP_VSE) || (req_i.op == vlsu_pkg::OP_VSSE);
  assign is_strided = (req_i.op == vlsu_pkg::OP_VLSE) || (req_i.op == vlsu_pkg::OP_VSSE);
  assign esize      = 3'd1 << req_i.vsew;
  assign vl_bytes   = 9'(req_i.vl) << req_i.vsew;

  // The first element is issued in the start cycle itself
  assign cur_byte   = (state_q == IDLE) ? rbyte_t'(lane_idx_i * vlsu_pkg::WORD_BYTES) : byte_q;
  assign walking    = (state_q == IDLE) ? start_i : (state_q == RUN);
  assign elem_valid = {1'b0, cur_byte} < vl_bytes;
  assign ld_credit  = ld_cnt_q < cnt_t'(vlsu_pkg::LOAD_DEPTH);
  assign issue      = walking && elem_valid && (is_store || ld_credit);

  // Step inside the word, then jump over the words of the other lanes
  always_comb begin
    nxt_byte = cur_byte + rbyte_t'(esize);
    if (nxt_byte[1:0] == 2'b00) begin
      nxt_byte = nxt_byte + rbyte_t'((vlsu_pkg::NR_PORTS - 1) * vlsu_pkg::WORD_BYTES);
    end
  end

  assign last_elem = {1'b0, nxt_byte} >= vl_bytes;
  assign elem_idx  = vlsu_pkg::vl_t'(cur_byte >> req_i.vsew);
  assign step      = is_strided ? req_i.stride : addr_t'(esize);
  assign elem_addr = req_i.base + addr_t'(elem_idx) * step;
  assign cur_vaddr = vlsu_pkg::vrf_addr_t'(req_i.vreg) *
                     vlsu_pkg::vrf_addr_t'(vlsu_pkg::VREG_WORDS) +
                     vlsu_pkg::vrf_addr_t'(cur_byte / (vlsu_pkg::WORD_BYTES * vlsu_pkg::NR_PORTS));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      byte_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE, RUN: begin
          if (issue) begin
            byte_q  <= nxt_byte;
            state_q <= last_elem ? DRAIN : RUN;
          end
        end
        DRAIN: begin
          // A store ends after its last request, a load with its last write
          if (is_store ? st_valid_q : (ld_pop && ld_cnt_q == cnt_t'(1))) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // A lane without elements reports right away
  assign done_o = done_q || ((state_q == IDLE) && start_i && !elem_valid);

  //////////////////////
  // Load queue
  //////////////////////

  assign ld_push = issue && !is_store;
  assign ld_pop  = mem_res_valid_i;
  assign head    = ldq_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      ld_cnt_q   <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      if (ld_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (ld_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      ld_cnt_q   <= ld_cnt_q + cnt_t'(ld_push) - cnt_t'(ld_pop);
      wr_valid_q <= ld_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_push) begin
      ldq_q[wptr_q].vaddr <= cur_vaddr;
      ldq_q[wptr_q].boff  <= cur_byte[1:0];
      ldq_q[wptr_q].moff  <= elem_addr[1:0];
      ldq_q[wptr_q].vsew  <= req_i.vsew;
    end
    // Result bytes go from the memory byte lane to the register byte lane
    if (ld_pop) begin
      wr_q.addr <= head.vaddr;
      wr_q.data <= rotl_bytes(mem_rdata_i, head.boff - head.moff);
      wr_q.be   <= elem_mask(head.vsew) << head.boff;
    end
  end

  //////////////////////
  // Store stage
  //////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_valid_q <= 1'b0;
    end else begin
      st_valid_q <= issue && is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue && is_store) begin
      st_q.maddr <= {elem_addr[vlsu_pkg::MEM_AW-1:2], 2'b00};
      st_q.boff  <= cur_byte[1:0];
      st_q.moff  <= elem_addr[1:0];
      st_q.vsew  <= req_i.vsew;
    end
  end

  //////////////////////
  // Outputs
  //////////////////////

  assign vrf_re_o        = issue && is_store;
  assign vrf_raddr_o     = cur_vaddr;
  assign vrf_we_o        = wr_valid_q;
  assign vrf_wr_o        = wr_q;
  assign mem_req_valid_o = st_valid_q || ld_push;

  always_comb begin
    if (is_store) begin
      mem_req_o.addr  = st_q.maddr;
      mem_req_o.we    = 1'b1;
      mem_req_o.strb  = elem_mask(st_q.vsew) << st_q.moff;
      mem_req_o.wdata = rotl_bytes(vrf_rdata_i, st_q.moff - st_q.boff);
    end else begin
      mem_req_o.addr  = {elem_addr[vlsu_pkg::MEM_AW-1:2], 2'b00};
      mem_req_o.we    = 1'b0;
      mem_req_o.strb  = elem_mask(req_i.vsew) << elem_addr[1:0];
      mem_req_o.wdata = '0;
    end
  end

endmodule

/* rtl/vlsu_complete.sv */
// One response per instruction; every lane must report done exactly once after each start
`timescale 1ns/1ps

module vlsu_complete (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          start_i,
  input  logic [vlsu_pkg::NR_PORTS-1:0] done_i,
  input  vlsu_pkg::vlsu_req_t           req_i,
  output logic                          finish_o,
  output logic                          rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t           rsp_o
);

  logic [vlsu_pkg::NR_PORTS-1:0] pending_q, pending_d;
  logic                          fire;

  // Empty lanes report in the start cycle, so they never become pending
  assign pending_d = start_i ? ~done_i : (pending_q & ~done_i);
  assign fire      = (start_i || (|pending_q)) && (pending_d == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q   <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      pending_q   <= pending_d;
      rsp_valid_o <= fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      rsp_o.id   <= req_i.id;
      rsp_o.vreg <= req_i.vreg;
    end
  end

  // Dispatch frees up together with the response
  assign finish_o = rsp_valid_o;

endmodule

/* rtl/vlsu_top.sv */
// Vector load/store unit; single-cycle strobes without back-pressure on every outside port
`timescale 1ns/1ps

module vlsu_top (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // Instruction in
  input  logic                                              req_valid_i,
  input  vlsu_pkg::vlsu_req_t                               req_i,
  output logic                                              req_ready_o,
  // Memory ports
  output logic                [vlsu_pkg::NR_PORTS-1:0]      mem_req_valid_o,
  output vlsu_pkg::mem_req_t  [vlsu_pkg::NR_PORTS-1:0]      mem_req_o,
  input  logic                [vlsu_pkg::NR_PORTS-1:0]      mem_res_valid_i,
  input  vlsu_pkg::word_t     [vlsu_pkg::NR_PORTS-1:0]      mem_rdata_i,
  // Register file banks
  output logic                [vlsu_pkg::NR_PORTS-1:0]      vrf_re_o,
  output vlsu_pkg::vrf_addr_t [vlsu_pkg::NR_PORTS-1:0]      vrf_raddr_o,
  input  vlsu_pkg::word_t     [vlsu_pkg::NR_PORTS-1:0]      vrf_rdata_i,
  output logic                [vlsu_pkg::NR_PORTS-1:0]      vrf_we_o,
  output vlsu_pkg::vrf_wr_t   [vlsu_pkg::NR_PORTS-1:0]      vrf_wr_o,
  // Response
  output logic                                              rsp_valid_o,
  output vlsu_pkg::vlsu_rsp_t                               rsp_o
);

  logic                          start;
  logic                          finish;
  logic [vlsu_pkg::NR_PORTS-1:0] done;
  vlsu_pkg::vlsu_req_t           active;

  vlsu_dispatch u_dispatch (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .finish_i   (finish),
    .req_ready_o(req_ready_o),
    .start_o    (start),
    .active_o   (active)
  );

  // Lane i owns bank i and memory port i
  for (genvar i = 0; i < vlsu_pkg::NR_PORTS; i++) begin : gen_lane
    vlsu_lane u_lane (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .lane_idx_i     (i),
      .start_i        (start),
      .req_i          (active),
      .vrf_re_o       (vrf_re_o[i]),
      .vrf_raddr_o    (vrf_raddr_o[i]),
      .vrf_rdata_i    (vrf_rdata_i[i]),
      .vrf_we_o       (vrf_we_o[i]),
      .vrf_wr_o       (vrf_wr_o[i]),
      .mem_req_valid_o(mem_req_valid_o[i]),
      .mem_req_o      (mem_req_o[i]),
      .mem_res_valid_i(mem_res_valid_i[i]),
      .mem_rdata_i    (mem_rdata_i[i]),
      .done_o         (done[i])
    );
  end

  vlsu_complete u_complete (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .done_i     (done),
    .req_i      (active),
    .finish_o   (finish),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o)
  );

endmodule

/* sim/vlsu_chk.sv */
// Bound into vlsu_top; in-flight loads are counted at the memory ports, not read from the lanes
`timescale 1ns/1ps

module vlsu_chk (
  input logic                                         clk_i,
  input logic                                         rst_n_i,
  input logic                                         req_valid_i,
  input logic                                         req_ready_i,
  input vlsu_pkg::vlsu_req_t                          req_i,
  input logic                                         rsp_valid_i,
  input logic                [vlsu_pkg::NR_PORTS-1:0] mem_req_valid_i,
  input vlsu_pkg::mem_req_t  [vlsu_pkg::NR_PORTS-1:0] mem_req_i,
  input logic                [vlsu_pkg::NR_PORTS-1:0] mem_res_valid_i
);

  logic store_q;

  // Opcode class of the instruction taken at the last accept
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      store_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      store_q <= (req_i.op == vlsu_pkg::OP_VSE) || (req_i.op == vlsu_pkg::OP_VSSE);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) req_valid_i |-> req_ready_i)
    else $error("instruction offered while req_ready_o is low");

  assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_i |=> !rsp_valid_i)
    else $error("rsp_valid_o high two cycles in a row");

  for (genvar p = 0; p < vlsu_pkg::NR_PORTS; p++) begin : gen_port
    logic       ld_issue;
    logic [3:0] inflight_q;

    assign ld_issue = mem_req_valid_i[p] && !mem_req_i[p].we;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        inflight_q <= '0;
      end else if (ld_issue && !mem_res_valid_i[p]) begin
        inflight_q <= inflight_q + 4'd1;
      end else if (!ld_issue && mem_res_valid_i[p]) begin
        inflight_q <= inflight_q - 4'd1;
      end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     mem_req_valid_i[p] |-> (mem_req_i[p].we == store_q))
      else $error("port %0d write enable disagrees with the accepted opcode", p);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     inflight_q <= 4'(vlsu_pkg::LOAD_DEPTH))
      else $error("port %0d has more loads in flight than the queue holds", p);
  end

endmodule

bind vlsu_top vlsu_chk u_chk (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .req_ready_i    (req_ready_o),
  .req_i          (req_i),
  .rsp_valid_i    (rsp_valid_o),
  .mem_req_valid_i(mem_req_valid_o),
  .mem_req_i      (mem_req_o),
  .mem_res_valid_i(mem_res_valid_i)
);

/* sim/vlsu_tb.sv */
// Run from the project root; memory model covers byte addresses 0 to 0x3ff, wider ones wrap
`timescale 1ns/1ps

module vlsu_tb;

  logic                                         clk_i;
  logic                                         rst_n_i;
  logic                                         req_valid_i;
  vlsu_pkg::vlsu_req_t                          req_i;
  logic                                         req_ready_o;
  logic                [vlsu_pkg::NR_PORTS-1:0] mem_req_valid_o;
  vlsu_pkg::mem_req_t  [vlsu_pkg::NR_PORTS-1:0] mem_req_o;
  logic                [vlsu_pkg::NR_PORTS-1:0] mem_res_valid_i = '0;
  vlsu_pkg::word_t     [vlsu_pkg::NR_PORTS-1:0] mem_rdata_i = '0;
  logic                [vlsu_pkg::NR_PORTS-1:0] vrf_re_o;
  vlsu_pkg::vrf_addr_t [vlsu_pkg::NR_PORTS-1:0] vrf_raddr_o;
  vlsu_pkg::word_t     [vlsu_pkg::NR_PORTS-1:0] vrf_rdata_i = '0;
  logic                [vlsu_pkg::NR_PORTS-1:0] vrf_we_o;
  vlsu_pkg::vrf_wr_t   [vlsu_pkg::NR_PORTS-1:0] vrf_wr_o;
  logic                                         rsp_valid_o;
  vlsu_pkg::vlsu_rsp_t                          rsp_o;

  // Memory and bank models, each with a shadow copy for the reference model
  vlsu_pkg::word_t mem      [256];
  vlsu_pkg::word_t mem_ref  [256];
  vlsu_pkg::word_t vrf      [vlsu_pkg::NR_PORTS][256];
  vlsu_pkg::word_t vrf_ref  [vlsu_pkg::NR_PORTS][256];
  // Load results per port with the cycle they are due
  vlsu_pkg::word_t res_data [vlsu_pkg::NR_PORTS][$];
  int              res_due  [vlsu_pkg::NR_PORTS][$];
  int              last_due [vlsu_pkg::NR_PORTS] = '{default: -1};
  logic [31:0]     vec      [512];

  int                  seed = 32'ha62e;
  int                  cyc = 0;
  int                  limit;
  int                  errors = 0;
  int                  checks = 0;
  int                  mreq_cnt = 0;
  int                  re_cnt = 0;
  int                  we_cnt = 0;
  int                  rsp_cnt = 0;
  int                  acc_cyc = 0;
  int                  rsp_cyc = 0;
  logic                busy = 1'b0;
  logic                rsp_prev = 1'b0;
  vlsu_pkg::vlsu_rsp_t cur_rsp = '0;

  vlsu_top uut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_res_valid_i(mem_res_valid_i),
    .mem_rdata_i    (mem_rdata_i),
    .vrf_re_o       (vrf_re_o),
    .vrf_raddr_o    (vrf_raddr_o),
    .vrf_rdata_i    (vrf_rdata_i),
    .vrf_we_o       (vrf_we_o),
    .vrf_wr_o       (vrf_wr_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : cycle_limit
    cyc <= cyc + 1;
    if (cyc > limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", limit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  // Element e lives at base + e*t in memory and at register byte e*s
  task automatic apply_reference(input vlsu_pkg::vlsu_req_t r);
    int          s;
    int          b;
    int          lane;
    int          word;
    int          mb;
    int          rb;
    logic [31:0] a;
    logic [31:0] t;
    s = 1 << r.vsew;
    t = (r.op == vlsu_pkg::OP_VLSE || r.op == vlsu_pkg::OP_VSSE) ? r.stride : 32'(s);
    for (int e = 0; e < int'(r.vl); e++) begin
      a    = r.base + 32'(e) * t;
      b    = e * s;
      lane = (b / vlsu_pkg::WORD_BYTES) % vlsu_pkg::NR_PORTS;
      word = r.vreg * vlsu_pkg::VREG_WORDS + b / (vlsu_pkg::WORD_BYTES * vlsu_pkg::NR_PORTS);
      for (int k = 0; k < s; k++) begin
        mb = 8 * (int'(a[1:0]) + k);
        rb = 8 * (b % vlsu_pkg::WORD_BYTES + k);
        if (r.op == vlsu_pkg::OP_VSE || r.op == vlsu_pkg::OP_VSSE) begin
          mem_ref[a[9:2]][mb +: 8] = vrf_ref[lane][word][rb +: 8];
        end else begin
          vrf_ref[lane][word][rb +: 8] = mem_ref[a[9:2]][mb +: 8];
        end
      end
    end
  endtask

  ////////////////////
  // Port models
  ////////////////////

  always @(posedge clk_i) begin : port_models
    int lat;
    int due;
    if (rst_n_i) begin
      for (int p = 0; p < vlsu_pkg::NR_PORTS; p++) begin
        if (vrf_re_o[p]) begin
          re_cnt++;
          vrf_rdata_i[p] <= vrf[p][vrf_raddr_o[p]];
        end
        if (vrf_we_o[p]) begin
          we_cnt++;
          for (int k = 0; k < vlsu_pkg::WORD_BYTES; k++) begin
            if (vrf_wr_o[p].be[k]) begin
              vrf[p][vrf_wr_o[p].addr][8*k +: 8] = vrf_wr_o[p].data[8*k +: 8];
            end
          end
        end
        if (mem_req_valid_o[p]) begin
          mreq_cnt++;
          if (mem_req_o[p].we) begin
            for (int k = 0; k < vlsu_pkg::WORD_BYTES; k++) begin
              if (mem_req_o[p].strb[k]) begin
                mem[mem_req_o[p].addr[9:2]][8*k +: 8] = mem_req_o[p].wdata[8*k +: 8];
              end
            end
          end else begin
            // 1 to 3 cycles of latency, never overtaking an older result
            lat = 1 + int'($unsigned($random(seed)) % 3);
            due = (cyc + lat - 1 > last_due[p]) ? cyc + lat - 1 : last_due[p] + 1;
            res_data[p].push_back(mem[mem_req_o[p].addr[9:2]]);
            res_due[p].push_back(due);
            last_due[p] = due;
          end
        end
        if (res_due[p].size() > 0 && res_due[p][0] <= cyc) begin
          mem_res_valid_i[p] <= 1'b1;
          mem_rdata_i[p]     <= res_data[p].pop_front();
          res_due[p].delete(0);
        end else begin
          mem_res_valid_i[p] <= 1'b0;
        end
      end

      // Handshake rules around accept and response
      if (busy && req_ready_o) begin
        report_problem("req_ready_o went high while an instruction was in flight");
      end
      if (rsp_prev && !req_ready_o) begin
        report_problem("req_ready_o stayed low the cycle after the response");
      end
      if (req_valid_i && req_ready_o) begin
        busy    = 1'b1;
        acc_cyc = cyc;
      end
      if (rsp_valid_o) begin
        if (!busy) begin
          report_problem("a response came with no instruction in flight");
        end
        rsp_cnt++;
        rsp_cyc = cyc;
        compare_value("response id", 32'(cur_rsp.id), 32'(rsp_o.id));
        compare_value("response vreg", 32'(cur_rsp.vreg), 32'(rsp_o.vreg));
        busy = 1'b0;
      end
      rsp_prev = rsp_valid_o;
    end
  end

  ////////////////////
  // Vector replay
  ////////////////////

  initial begin : run_vectors
    vlsu_pkg::vlsu_req_t r;
    int                  nvec;
    int                  exp_cnt;
    int                  rsp_before;
    logic                store;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    for (int i = 0; i < 512; i++) begin
      vec[i] = '1;
    end
    $readmemh("sim/vlsu_vectors.txt", vec);
    nvec  = 0;
    limit = 0;
    while (nvec < 64 && vec[8*nvec] != 32'hffffffff) begin
      limit += 4 * int'(vec[8*nvec+2]) + 50;
      nvec++;
    end
    for (int w = 0; w < 256; w++) begin
      mem[w]     = {8'(w) ^ 8'h5a, ~8'(w), 8'(w) + 8'h31, 8'(w)};
      mem_ref[w] = mem[w];
      for (int p = 0; p < vlsu_pkg::NR_PORTS; p++) begin
        vrf[p][w]     = {8'(w) + 8'h80, 8'(p) ^ 8'hc6, 8'(w) ^ 8'h3c, ~8'(w)};
        vrf_ref[p][w] = vrf[p][w];
      end
    end
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int i = 0; i < nvec; i++) begin
      r.op     = vlsu_pkg::vlsu_op_e'(vec[8*i][1:0]);
      r.vsew   = vlsu_pkg::vsew_e'(vec[8*i+1][1:0]);
      r.vl     = vlsu_pkg::vl_t'(vec[8*i+2]);
      r.base   = vec[8*i+3];
      r.stride = vec[8*i+4];
      r.vreg   = vec[8*i+5][4:0];
      r.id     = vec[8*i+6][3:0];
      exp_cnt  = int'(vec[8*i+7]);
      store    = (r.op == vlsu_pkg::OP_VSE) || (r.op == vlsu_pkg::OP_VSSE);
      @(negedge clk_i);
      while (!req_ready_o) @(negedge clk_i);
      apply_reference(r);
      mreq_cnt     = 0;
      re_cnt       = 0;
      we_cnt       = 0;
      rsp_before   = rsp_cnt;
      cur_rsp.id   = r.id;
      cur_rsp.vreg = r.vreg;
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_i       <= r;
      @(posedge clk_i);
      req_valid_i <= 1'b0;
      while (rsp_cnt == rsp_before) @(negedge clk_i);

      compare_value($sformatf("vector %0d memory requests", i), exp_cnt, mreq_cnt);
      compare_value($sformatf("vector %0d bank reads", i), store ? int'(r.vl) : 0, re_cnt);
      compare_value($sformatf("vector %0d bank writes", i), store ? 0 : int'(r.vl), we_cnt);
      if (r.vl == 0) begin
        compare_value($sformatf("vector %0d response latency", i), 2, rsp_cyc - acc_cyc);
      end
      for (int w = 0; w < 256; w++) begin
        compare_value($sformatf("vector %0d memory word %0d", i, w), mem_ref[w], mem[w]);
        for (int p = 0; p < vlsu_pkg::NR_PORTS; p++) begin
          compare_value($sformatf("vector %0d bank %0d word %0d", i, p, w),
                        vrf_ref[p][w], vrf[p][w]);
        end
      end
    end

    repeat (4) @(negedge clk_i);
    compare_value("response count", nvec, rsp_cnt);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sim/vlsu_vectors.txt */
// Columns, all hex: op vsew vl base stride vreg id expected_memory_requests
// op 0 vle, 1 vlse, 2 vse, 3 vsse; vsew 0 is 8-bit, 1 is 16-bit, 2 is 32-bit
0 0 40 000 0 01 1 40
0 1 20 040 0 02 2 20
0 2 10 080 0 03 3 10
0 0 07 0c3 0 04 4 07
0 1 05 0d2 0 05 5 05
0 2 03 0e4 0 06 6 03
0 0 00 100 0 07 7 00
1 0 10 100 5 08 8 10
1 1 0c 150 6 09 9 0c
1 2 08 1a0 c 0a a 08
1 2 10 200 0 0b b 10
1 0 21 210 3 0c c 21
1 1 03 2fe fffffffe 0d d 03
2 0 11 300 0 01 e 11
2 1 09 320 0 02 f 09
2 2 06 340 0 03 0 06
3 0 0a 360 7 0c 1 0a
3 1 08 3a0 6 09 2 08
3 2 05 3d0 8 0a 3 05
3 0 00 000 4 00 4 00
3 2 03 010 fffffff8 1f 5 03
0 0 40 300 0 10 6 40
1 0 40 000 1 11 7 40
2 0 40 080 0 10 8 40
0 2 00 000 0 12 9 00
1 1 20 100 2 13 a 20
3 0 01 3ff 0 1e b 01
0 0 01 005 0 1e c 01

/* project.f */
rtl/vlsu_pkg.sv
rtl/vlsu_dispatch.sv
rtl/vlsu_lane.sv
rtl/vlsu_complete.sv
rtl/vlsu_top.sv
sim/vlsu_chk.sv
sim/vlsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run from the project root; the exit status is nonzero unless the pass line appears
verilator --binary --timing --assert -Wno-fatal --top-module vlsu_tb -f project.f \
  && ./obj_dir/Vvlsu_tb | tee /dev/stderr | grep -x "No errors" > /dev/null \
  || exit 1
